// File: sources.f
+incdir+verilog
verilog/btac_pkg.sv
verilog/btac_store.sv
verilog/btac_update_select.sv
verilog/btac_lookup.sv
verilog/btac_ctrl.sv
verilog/btac.sv
verif/btac_clock_gen.sv
verif/btac_tb.sv

// File: verif/btac_clock_gen.sv
module btac_clock_gen #(
  parameter int period       = 40,
  parameter int reset_cycles = 3
) (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // low across the first rising edges, released on a falling edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

// File: verif/btac_tb.sv
`include "btac_defines.svh"

module btac_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int stim_cycles = 200;             // stimulus budget of all tests.
  localparam int max_cycles  = 2 * stim_cycles;

  logic clock;
  logic reset;
  logic clear;
  logic [`BTAC_XLEN-1:0] get_pc;
  logic upd_jump0, upd_branch0, upd_jump1, upd_branch1;
  logic [`BTAC_XLEN-1:0] upd_pc0, upd_addr0, upd_npc0;
  logic [`BTAC_XLEN-1:0] upd_pc1, upd_addr1, upd_npc1;
  logic taken;
  logic [`BTAC_XLEN-1:0] taddr, tpc;
  logic pred_branch, pred_miss;
  logic [`BTAC_XLEN-1:0] pred_baddr, pred_pc, pred_maddr;

  int seed        = 32'h9e96;
  int errors      = 0;
  int errors_seen = 0;
  int tests_run   = 0;
  int tests_failed = 0;
  int cycle_count = 0;
  int exp_hits    = 0;

  // reference model, entries keyed by index.
  logic [`BTAC_XLEN-1:0] model_pc   [int];
  logic [`BTAC_XLEN-1:0] model_addr [int];
  logic [`BTAC_XLEN-1:0] model_npc  [int];
  logic                  model_pending = 1'b0;
  logic [`BTAC_XLEN-1:0] model_taddr;
  logic [`BTAC_XLEN-1:0] model_tpc;

  logic                  e_hit, e_miss;
  logic [`BTAC_XLEN-1:0] e_baddr, e_pc, e_maddr;

  btac_clock_gen u_clock (.clock(clock), .reset(reset));

  btac u_dut (
    .clock(clock), .reset(reset), .clear(clear), .get_pc(get_pc),
    .upd_jump0(upd_jump0), .upd_branch0(upd_branch0), .upd_pc0(upd_pc0),
    .upd_addr0(upd_addr0), .upd_npc0(upd_npc0),
    .upd_jump1(upd_jump1), .upd_branch1(upd_branch1), .upd_pc1(upd_pc1),
    .upd_addr1(upd_addr1), .upd_npc1(upd_npc1),
    .taken(taken), .taddr(taddr), .tpc(tpc),
    .pred_branch(pred_branch), .pred_baddr(pred_baddr), .pred_pc(pred_pc),
    .pred_miss(pred_miss), .pred_maddr(pred_maddr)
  );

  task automatic log_mismatch(input string what, input logic [`BTAC_XLEN-1:0] got,
                              input logic [`BTAC_XLEN-1:0] want);
    errors++;
    $display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
  endtask

  task automatic log_rule(input string what);
    errors++;
    $display("Fail %0t: %s", $time, what);
  endtask

  function automatic logic [`BTAC_XLEN-1:0] random_pc();
    return $random(seed) & 32'hffff_fffc; // word aligned.
  endfunction

  // ***********************************************************************
  // reference model
  // ***********************************************************************

  task automatic compute_expected();
    int idx;
    logic pend, rjump, rbranch;
    logic [`BTAC_XLEN-1:0] paddr, pnpc, raddr;
    idx     = int'(get_pc[`BTAC_INDEX_W+1:2]);
    e_hit   = 1'b0;
    e_baddr = '0;
    e_pc    = '0;
    if (model_pc.exists(idx)) begin
      if (model_pc[idx] == get_pc) begin
        e_hit   = 1'b1;
        e_baddr = model_addr[idx];
        e_pc    = model_npc[idx];
      end
    end
    pend  = taken || model_pending;      // a taken strobe counts at once.
    paddr = taken ? taddr : model_taddr;
    pnpc  = taken ? tpc : model_tpc;
    if (upd_jump0 || upd_branch0) begin
      rjump   = upd_jump0;
      rbranch = !upd_jump0;
      raddr   = upd_addr0;
    end else begin
      rjump   = upd_jump1;
      rbranch = upd_branch1 && !upd_jump1;
      raddr   = upd_addr1;
    end
    e_miss  = 1'b0;
    e_maddr = '0;
    if (rjump) begin
      e_miss  = !pend || (raddr != paddr);
      e_maddr = raddr;
    end else if (rbranch && pend) begin
      e_miss  = 1'b1;                    // predicted taken, fell through.
      e_maddr = pnpc;
    end
    if (clear) begin
      e_hit   = 1'b0;
      e_baddr = '0;
      e_pc    = '0;
      e_miss  = 1'b0;
      e_maddr = '0;
    end
  endtask

  task automatic store_entry(input logic [`BTAC_XLEN-1:0] pc, input logic [`BTAC_XLEN-1:0] addr,
                             input logic [`BTAC_XLEN-1:0] npc);
    int idx;
    idx = int'(pc[`BTAC_INDEX_W+1:2]);
    model_pc[idx]   = pc;
    model_addr[idx] = addr;
    model_npc[idx]  = npc;
  endtask

  task automatic advance_model();
    logic resolves;
    resolves = upd_jump0 || upd_branch0 || upd_jump1 || upd_branch1;
    if (!clear && upd_jump0) begin
      store_entry(upd_pc0, upd_addr0, upd_npc0);
    end else if (!clear && upd_jump1) begin
      store_entry(upd_pc1, upd_addr1, upd_npc1);
    end
    if (clear) begin
      model_pending = 1'b0;
    end else if ((taken || model_pending) && !resolves) begin
      if (taken) begin
        model_taddr = taddr;
        model_tpc   = tpc;
      end
      model_pending = 1'b1;
    end else begin
      model_pending = 1'b0;
    end
  endtask

  // outputs still hold their pre-edge values here.
  always @(posedge clock) begin
    if (reset) begin
      compute_expected();
      if (e_hit) exp_hits++;
      assert (pred_branch === e_hit)
        else log_mismatch("pred_branch", 32'(pred_branch), 32'(e_hit));
      assert (pred_baddr === e_baddr) else log_mismatch("pred_baddr", pred_baddr, e_baddr);
      assert (pred_pc === e_pc) else log_mismatch("pred_pc", pred_pc, e_pc);
      assert (pred_miss === e_miss)
        else log_mismatch("pred_miss", 32'(pred_miss), 32'(e_miss));
      assert (pred_maddr === e_maddr) else log_mismatch("pred_maddr", pred_maddr, e_maddr);
      advance_model();
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    clear |-> (!pred_branch && !pred_miss && pred_baddr == '0 && pred_pc == '0
               && pred_maddr == '0))
    else log_rule("outputs not zero during clear");

  assert property (@(posedge clock) disable iff (!reset)
    !pred_branch |-> (pred_baddr == '0 && pred_pc == '0))
    else log_rule("lookup fields not zero without a hit");

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ***********************************************************************
  // stimulus
  // ***********************************************************************

  task automatic idle_inputs();
    clear       = 1'b0;
    taken       = 1'b0;
    taddr       = '0;
    tpc         = '0;
    upd_jump0   = 1'b0;
    upd_branch0 = 1'b0;
    upd_pc0     = '0;
    upd_addr0   = '0;
    upd_npc0    = '0;
    upd_jump1   = 1'b0;
    upd_branch1 = 1'b0;
    upd_pc1     = '0;
    upd_addr1   = '0;
    upd_npc1    = '0;
    get_pc      = random_pc();
  endtask

  task automatic next_cycle();
    @(negedge clock);
    idle_inputs();
  endtask

  task automatic set_slot0(input logic jump, input logic branch,
                           input logic [`BTAC_XLEN-1:0] pc, input logic [`BTAC_XLEN-1:0] addr);
    upd_jump0   = jump;
    upd_branch0 = branch;
    upd_pc0     = pc;
    upd_addr0   = addr;
    upd_npc0    = pc + 4;
  endtask

  task automatic set_slot1(input logic jump, input logic branch,
                           input logic [`BTAC_XLEN-1:0] pc, input logic [`BTAC_XLEN-1:0] addr);
    upd_jump1   = jump;
    upd_branch1 = branch;
    upd_pc1     = pc;
    upd_addr1   = addr;
    upd_npc1    = pc + 4;
  endtask

  task automatic predict(input logic [`BTAC_XLEN-1:0] addr, input logic [`BTAC_XLEN-1:0] npc);
    taken = 1'b1;
    taddr = addr;
    tpc   = npc;
  endtask

  task automatic end_test(input string name);
    @(negedge clock);                    // last cycle checked by now.
    idle_inputs();
    tests_run++;
    if (errors == errors_seen) begin
      $display("%0t: %s passed", $time, name);
    end else begin
      tests_failed++;
      $display("%0t: %s failed with %0d errors", $time, name, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  initial begin
    logic [`BTAC_XLEN-1:0] pc_a, pc_b, tgt, tgt2;
    logic [`BTAC_XLEN-1:0] kept [4];
    idle_inputs();
    @(posedge reset);

    repeat (20) next_cycle();
    end_test("empty after reset");

    for (int i = 0; i < 4; i++) begin
      pc_a    = random_pc();
      kept[i] = pc_a;
      next_cycle();
      set_slot0(1'b1, 1'b0, pc_a, random_pc());
      get_pc = pc_a;                     // no bypass, still a miss.
      next_cycle();
      get_pc = pc_a;
      next_cycle();
      get_pc = pc_a ^ 32'h8000_0000;     // same index, other upper bits.
    end
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      get_pc = kept[i];
    end
    end_test("write then hit");

    pc_a = random_pc();
    next_cycle();
    set_slot0(1'b1, 1'b0, pc_a, random_pc());
    set_slot1(1'b1, 1'b0, pc_a + 4, random_pc());
    next_cycle();
    get_pc = pc_a;
    next_cycle();
    get_pc = pc_a + 4;
    pc_a = random_pc();
    next_cycle();
    set_slot0(1'b0, 1'b1, pc_a, pc_a + 4);
    set_slot1(1'b1, 1'b0, pc_a + 8, random_pc());
    next_cycle();
    get_pc = pc_a + 8;
    next_cycle();
    get_pc = pc_a;
    end_test("slot priority");

    pc_a = random_pc();
    tgt  = random_pc();
    tgt2 = random_pc();
    next_cycle();
    predict(tgt, pc_a + 4);
    next_cycle();
    next_cycle();
    set_slot0(1'b1, 1'b0, pc_a, tgt);
    next_cycle();
    predict(tgt, pc_a + 4);
    next_cycle();
    set_slot1(1'b1, 1'b0, pc_a, tgt2);
    next_cycle();
    predict(tgt, pc_a + 4);
    set_slot0(1'b1, 1'b0, pc_a, tgt);  // resolved in the strobe cycle.
    end_test("pending resolved by a jump");

    next_cycle();
    predict(tgt, pc_a + 4);
    next_cycle();
    next_cycle();
    set_slot0(1'b0, 1'b1, pc_a, pc_a + 4);
    next_cycle();
    set_slot0(1'b1, 1'b0, pc_a, tgt);
    end_test("pending resolved by a branch");

    pc_a = random_pc();
    pc_b = pc_a + 4;
    next_cycle();
    set_slot0(1'b1, 1'b0, pc_a, tgt);
    next_cycle();
    get_pc = pc_a;
    next_cycle();
    clear = 1'b1;
    set_slot0(1'b1, 1'b0, pc_b, tgt2);
    get_pc = pc_a;
    next_cycle();
    get_pc = pc_b;
    next_cycle();
    predict(tgt2, pc_b + 4);
    next_cycle();
    clear = 1'b1;
    next_cycle();
    set_slot0(1'b1, 1'b0, pc_b, tgt2); // prediction gone, so a miss.
    next_cycle();
    get_pc = pc_a;
    end_test("clear");

    if (exp_hits == 0) begin
      errors++;
      $display("no lookup hit was exercised during the run");
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/btac.sv
`include "btac_defines.svh"

module btac
  import btac_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear,
  input  logic [`BTAC_XLEN-1:0]   get_pc,
  input  logic                    upd_jump0,
  input  logic                    upd_branch0,
  input  logic [`BTAC_XLEN-1:0]   upd_pc0,
  input  logic [`BTAC_XLEN-1:0]   upd_addr0,
  input  logic [`BTAC_XLEN-1:0]   upd_npc0,
  input  logic                    upd_jump1,
  input  logic                    upd_branch1,
  input  logic [`BTAC_XLEN-1:0]   upd_pc1,
  input  logic [`BTAC_XLEN-1:0]   upd_addr1,
  input  logic [`BTAC_XLEN-1:0]   upd_npc1,
  input  logic                    taken,
  input  logic [`BTAC_XLEN-1:0]   taddr,
  input  logic [`BTAC_XLEN-1:0]   tpc,
  output logic                    pred_branch,
  output logic [`BTAC_XLEN-1:0]   pred_baddr,
  output logic [`BTAC_XLEN-1:0]   pred_pc,
  output logic                    pred_miss,
  output logic [`BTAC_XLEN-1:0]   pred_maddr
);

  logic                     write_req;
  logic                     write_en;
  logic [`BTAC_INDEX_W-1:0] write_index;
  logic [`BTAC_XLEN-1:0]    write_pc;
  logic [`BTAC_XLEN-1:0]    write_addr;
  logic [`BTAC_XLEN-1:0]    write_npc;
  slot_kind_t               res_kind;
  logic [`BTAC_XLEN-1:0]    res_addr;

  logic [`BTAC_INDEX_W-1:0] read_index;
  logic                     read_valid;
  logic [`BTAC_XLEN-1:0]    read_pc;
  logic [`BTAC_XLEN-1:0]    read_addr;
  logic [`BTAC_XLEN-1:0]    read_npc;

  logic                     hit;
  logic [`BTAC_XLEN-1:0]    hit_addr;
  logic [`BTAC_XLEN-1:0]    hit_npc;

  btac_update_select u_select (
    .upd_jump0   (upd_jump0),
    .upd_branch0 (upd_branch0),
    .upd_pc0     (upd_pc0),
    .upd_addr0   (upd_addr0),
    .upd_npc0    (upd_npc0),
    .upd_jump1   (upd_jump1),
    .upd_branch1 (upd_branch1),
    .upd_pc1     (upd_pc1),
    .upd_addr1   (upd_addr1),
    .upd_npc1    (upd_npc1),
    .write_req   (write_req),
    .write_index (write_index),
    .write_pc    (write_pc),
    .write_addr  (write_addr),
    .write_npc   (write_npc),
    .res_kind    (res_kind),
    .res_addr    (res_addr)
  );

  btac_store u_store (
    .clock       (clock),
    .reset       (reset),
    .write_en    (write_en),
    .write_index (write_index),
    .write_pc    (write_pc),
    .write_addr  (write_addr),
    .write_npc   (write_npc),
    .read_index  (read_index),
    .read_valid  (read_valid),
    .read_pc     (read_pc),
    .read_addr   (read_addr),
    .read_npc    (read_npc)
  );

  btac_lookup u_lookup (
    .get_pc     (get_pc),
    .read_index (read_index),
    .read_valid (read_valid),
    .read_pc    (read_pc),
    .read_addr  (read_addr),
    .read_npc   (read_npc),
    .hit        (hit),
    .hit_addr   (hit_addr),
    .hit_npc    (hit_npc)
  );

  btac_ctrl u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .taken       (taken),
    .taddr       (taddr),
    .tpc         (tpc),
    .write_req   (write_req),
    .res_kind    (res_kind),
    .res_addr    (res_addr),
    .hit         (hit),
    .hit_addr    (hit_addr),
    .hit_npc     (hit_npc),
    .write_en    (write_en),
    .pred_branch (pred_branch),
    .pred_baddr  (pred_baddr),
    .pred_pc     (pred_pc),
    .pred_miss   (pred_miss),
    .pred_maddr  (pred_maddr)
  );

endmodule

// File: verilog/btac_ctrl.sv
`include "btac_defines.svh"

module btac_ctrl
  import btac_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       taken,
  input  logic [`BTAC_XLEN-1:0]      taddr,
  input  logic [`BTAC_XLEN-1:0]      tpc,
  input  logic                       write_req,
  input  slot_kind_t                 res_kind,
  input  logic [`BTAC_XLEN-1:0]      res_addr,
  input  logic                       hit,
  input  logic [`BTAC_XLEN-1:0]      hit_addr,
  input  logic [`BTAC_XLEN-1:0]      hit_npc,
  output logic                       write_en,
  output logic                       pred_branch,
  output logic [`BTAC_XLEN-1:0]      pred_baddr,
  output logic [`BTAC_XLEN-1:0]      pred_pc,
  output logic                       pred_miss,
  output logic [`BTAC_XLEN-1:0]      pred_maddr
);

  track_state_t state;
  track_state_t state_next;

  logic [`BTAC_XLEN-1:0] held_addr;
  logic [`BTAC_XLEN-1:0] held_npc;

  logic                  pending;
  logic [`BTAC_XLEN-1:0] pend_addr;
  logic [`BTAC_XLEN-1:0] pend_npc;
  logic                  resolve;
  logic                  miss;
  logic [`BTAC_XLEN-1:0] maddr;

  // ***************************************************************************
  // pending prediction
  // ***************************************************************************

  // a taken strobe counts in its own cycle.
  assign pending   = taken | (state == track_pending);
  assign pend_addr = taken ? taddr : held_addr;
  assign pend_npc  = taken ? tpc   : held_npc;
  assign resolve   = (res_kind != slot_none);

  always_comb begin
    if (clear) begin
      state_next = track_idle; // flush drops the prediction.
    end else if (pending && !resolve) begin
      state_next = track_pending;
    end else begin
      state_next = track_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= track_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (taken && !clear) begin
      held_addr <= taddr;
      held_npc  <= tpc;
    end
  end

  // ***************************************************************************
  // resolution
  // ***************************************************************************

  always_comb begin
    miss  = 1'b0;
    maddr = '0;
    case (res_kind)
      slot_jump: begin
        maddr = res_addr;
        if (!pending) begin
          miss = 1'b1; // unpredicted taken transfer.
        end else begin
          miss = (res_addr != pend_addr);
        end
      end
      slot_branch: begin
        if (pending) begin
          miss  = 1'b1; // predicted taken, went sequential.
          maddr = pend_npc;
        end
      end
      default: begin
        miss  = 1'b0;
        maddr = '0;
      end
    endcase
  end

  // ***************************************************************************
  // outputs, all forced low by clear
  // ***************************************************************************

  assign write_en    = write_req & ~clear;
  assign pred_branch = hit & ~clear;
  assign pred_baddr  = clear ? '0 : hit_addr;
  assign pred_pc     = clear ? '0 : hit_npc;
  assign pred_miss   = miss & ~clear;
  assign pred_maddr  = clear ? '0 : maddr;

endmodule

// File: verilog/btac_defines.svh
`ifndef BTAC_DEFINES_SVH
`define BTAC_DEFINES_SVH

// ***************************************************************************
// address and table geometry
// ***************************************************************************

// width of every pc and target.
`define BTAC_XLEN 32

// number of entries, a power of two.
`define BTAC_DEPTH 64

// log2 of BTAC_DEPTH.
`define BTAC_INDEX_W 6

`endif

// File: verilog/btac_lookup.sv
`include "btac_defines.svh"

module btac_lookup (
  input  logic [`BTAC_XLEN-1:0]      get_pc,
  output logic [`BTAC_INDEX_W-1:0]   read_index,
  input  logic                       read_valid,
  input  logic [`BTAC_XLEN-1:0]      read_pc,
  input  logic [`BTAC_XLEN-1:0]      read_addr,
  input  logic [`BTAC_XLEN-1:0]      read_npc,
  output logic                       hit,
  output logic [`BTAC_XLEN-1:0]      hit_addr,
  output logic [`BTAC_XLEN-1:0]      hit_npc
);

  logic tag_match;

  assign read_index = get_pc[`BTAC_INDEX_W+1:2];

  // full pc compare, so aliases on the index never hit.
  assign tag_match = (read_pc == get_pc);
  assign hit       = read_valid & tag_match;

  // zero on a miss; unwritten entries hold no defined data.
  assign hit_addr = hit ? read_addr : '0;
  assign hit_npc  = hit ? read_npc  : '0;

endmodule

// File: verilog/btac_pkg.sv
`include "btac_defines.svh"

package btac_pkg;

  // what the chosen retire slot carries.
  typedef enum logic [1:0] {
    slot_none   = 2'd0,
    slot_jump   = 2'd1, // resolved taken.
    slot_branch = 2'd2  // resolved not taken.
  } slot_kind_t;

  // prediction tracker.
  typedef enum logic {
    track_idle    = 1'b0,
    track_pending = 1'b1
  } track_state_t;

endpackage

// File: verilog/btac_store.sv
`include "btac_defines.svh"

module btac_store (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       write_en,
  input  logic [`BTAC_INDEX_W-1:0]   write_index,
  input  logic [`BTAC_XLEN-1:0]      write_pc,
  input  logic [`BTAC_XLEN-1:0]      write_addr,
  input  logic [`BTAC_XLEN-1:0]      write_npc,
  input  logic [`BTAC_INDEX_W-1:0]   read_index,
  output logic                       read_valid,
  output logic [`BTAC_XLEN-1:0]      read_pc,
  output logic [`BTAC_XLEN-1:0]      read_addr,
  output logic [`BTAC_XLEN-1:0]      read_npc
);

  logic [`BTAC_XLEN-1:0] pc_mem   [`BTAC_DEPTH];
  logic [`BTAC_XLEN-1:0] addr_mem [`BTAC_DEPTH];
  logic [`BTAC_XLEN-1:0] npc_mem  [`BTAC_DEPTH];
  logic [`BTAC_DEPTH-1:0] valid;

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
    end else if (write_en) begin
      valid[write_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      pc_mem[write_index]   <= write_pc;
      addr_mem[write_index] <= write_addr;
      npc_mem[write_index]  <= write_npc;
    end
  end

  // asynchronous read, no write bypass.
  assign read_valid = valid[read_index];
  assign read_pc    = pc_mem[read_index];
  assign read_addr  = addr_mem[read_index];
  assign read_npc   = npc_mem[read_index];

endmodule

// File: verilog/btac_update_select.sv
`include "btac_defines.svh"

module btac_update_select
  import btac_pkg::*;
(
  input  logic                       upd_jump0,
  input  logic                       upd_branch0,
  input  logic [`BTAC_XLEN-1:0]      upd_pc0,
  input  logic [`BTAC_XLEN-1:0]      upd_addr0,
  input  logic [`BTAC_XLEN-1:0]      upd_npc0,
  input  logic                       upd_jump1,
  input  logic                       upd_branch1,
  input  logic [`BTAC_XLEN-1:0]      upd_pc1,
  input  logic [`BTAC_XLEN-1:0]      upd_addr1,
  input  logic [`BTAC_XLEN-1:0]      upd_npc1,
  output logic                       write_req,
  output logic [`BTAC_INDEX_W-1:0]   write_index,
  output logic [`BTAC_XLEN-1:0]      write_pc,
  output logic [`BTAC_XLEN-1:0]      write_addr,
  output logic [`BTAC_XLEN-1:0]      write_npc,
  output slot_kind_t                 res_kind,
  output logic [`BTAC_XLEN-1:0]      res_addr
);

  slot_kind_t kind0;
  slot_kind_t kind1;

  function automatic slot_kind_t classify(input logic jump, input logic branch);
    if (jump) begin
      return slot_jump; // jump flag wins over branch.
    end else if (branch) begin
      return slot_branch;
    end
    return slot_none;
  endfunction

  // ***************************************************************************
  // write slot: first jump in program order
  // ***************************************************************************

  assign write_req  = upd_jump0 | upd_jump1;
  assign write_pc   = upd_jump0 ? upd_pc0   : upd_pc1;
  assign write_addr = upd_jump0 ? upd_addr0 : upd_addr1;
  assign write_npc  = upd_jump0 ? upd_npc0  : upd_npc1;
  assign write_index = write_pc[`BTAC_INDEX_W+1:2]; // word aligned.

  // ***************************************************************************
  // resolving slot: first control transfer of either kind
  // ***************************************************************************

  assign kind0 = classify(upd_jump0, upd_branch0);
  assign kind1 = classify(upd_jump1, upd_branch1);

  always_comb begin
    if (kind0 != slot_none) begin
      res_kind = kind0;
      res_addr = upd_addr0;
    end else begin
      res_kind = kind1;
      res_addr = upd_addr1;
    end
  end

endmodule
